/* hdl/rv_ex_pkg.sv */
`default_nettype none

package rv_ex_pkg;

	// alu functions, same encoding as rv32i funct3
	localparam logic [2:0] alu_add  = 3'b000;
	localparam logic [2:0] alu_sll  = 3'b001;
	localparam logic [2:0] alu_slt  = 3'b010;
	localparam logic [2:0] alu_sltu = 3'b011;
	localparam logic [2:0] alu_xor  = 3'b100;
	localparam logic [2:0] alu_sr   = 3'b101;
	localparam logic [2:0] alu_or   = 3'b110;
	localparam logic [2:0] alu_and  = 3'b111;

	// branch kinds
	localparam logic [2:0] br_eq  = 3'b000;
	localparam logic [2:0] br_ne  = 3'b001;
	localparam logic [2:0] br_lt  = 3'b100;
	localparam logic [2:0] br_ge  = 3'b101;
	localparam logic [2:0] br_ltu = 3'b110;
	localparam logic [2:0] br_geu = 3'b111;

	// csr operations, bit 2 marks the uimm forms
	localparam logic [2:0] csr_rw  = 3'b001;
	localparam logic [2:0] csr_rs  = 3'b010;
	localparam logic [2:0] csr_rc  = 3'b011;
	localparam logic [2:0] csr_rwi = 3'b101;
	localparam logic [2:0] csr_rsi = 3'b110;
	localparam logic [2:0] csr_rci = 3'b111;

	// machine csr addresses
	localparam logic [11:0] csr_mstatus  = 12'h300;
	localparam logic [11:0] csr_mie      = 12'h304;
	localparam logic [11:0] csr_mtvec    = 12'h305;
	localparam logic [11:0] csr_mscratch = 12'h340;
	localparam logic [11:0] csr_mepc     = 12'h341;
	localparam logic [11:0] csr_mcause   = 12'h342;

	// exception causes
	localparam logic [31:0] cause_illegal = 32'd2;
	localparam logic [31:0] cause_ecall_m = 32'd11;

endpackage

`default_nettype wire

/* hdl/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  wire logic [31:0] op_a,
	input  wire logic [31:0] op_b,
	input  wire logic [2:0]  alu_func,
	input  wire logic        alu_sub,
	output logic      [31:0] alu_result
);

	import rv_ex_pkg::*;

	logic [31:0] add_b;
	logic [31:0] sum;
	logic [31:0] sll_res;
	logic [31:0] srl_res;
	logic [31:0] sra_res;
	logic [31:0] sr_res;
	logic        lt_s;
	logic        lt_u;

	// one adder, op_b inverted plus carry-in for sub
	assign add_b = op_b ^ {32{alu_sub}};
	assign sum   = op_a + add_b + {31'd0, alu_sub};

	// shifts use the low five bits only
	assign sll_res = op_a << op_b[4:0];
	assign srl_res = op_a >> op_b[4:0];
	assign sra_res = $unsigned($signed(op_a) >>> op_b[4:0]);

	// alu_sub doubles as the arithmetic shift select
	assign sr_res = alu_sub ? sra_res : srl_res;

	assign lt_s = $signed(op_a) < $signed(op_b);
	assign lt_u = op_a < op_b;

	always_comb begin
		case (alu_func)
			alu_add: begin
				alu_result = sum;
			end
			alu_sll: begin
				alu_result = sll_res;
			end
			alu_slt: begin
				alu_result = {31'd0, lt_s};
			end
			alu_sltu: begin
				alu_result = {31'd0, lt_u};
			end
			alu_xor: begin
				alu_result = op_a ^ op_b;
			end
			alu_sr: begin
				alu_result = sr_res;
			end
			alu_or: begin
				alu_result = op_a | op_b;
			end
			alu_and: begin
				alu_result = op_a & op_b;
			end
			default: begin
				alu_result = sum;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/ex_branch.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
	input  wire logic [31:0] rs1_data,
	input  wire logic [31:0] rs2_data,
	input  wire logic [31:2] pc_ex,
	input  wire logic        cmd_jal,
	input  wire logic        cmd_jalr,
	input  wire logic        cmd_br,
	input  wire logic        cmd_auipc,
	input  wire logic [2:0]  funct3,
	input  wire logic [20:1] imm_j,
	input  wire logic [12:1] imm_b,
	input  wire logic [11:0] imm_i,
	input  wire logic [31:12] imm_u,
	output logic      [31:2] jmp_adr,
	output logic             jmp_cond,
	output logic      [31:0] target,
	output logic      [31:0] link_data
);

	import rv_ex_pkg::*;

	logic [31:0] pc_byte;
	logic [31:0] base;
	logic [31:0] offset;
	logic        taken;

	assign pc_byte = {pc_ex, 2'b00};

	// jalr is relative to rs1, everything else to the pc
	assign base   = cmd_jalr ? rs1_data : pc_byte;
	assign offset = cmd_auipc ? {imm_u, 12'd0} :
	                cmd_jal   ? {{11{imm_j[20]}}, imm_j, 1'b0} :
	                cmd_jalr  ? {{20{imm_i[11]}}, imm_i} :
	                            {{19{imm_b[12]}}, imm_b, 1'b0};

	assign target  = base + offset;
	// low bits dropped, so jalr bit 0 clears itself
	assign jmp_adr = target[31:2];

	always_comb begin
		case (funct3)
			br_eq:   taken = rs1_data == rs2_data;
			br_ne:   taken = rs1_data != rs2_data;
			br_lt:   taken = $signed(rs1_data) < $signed(rs2_data);
			br_ge:   taken = $signed(rs1_data) >= $signed(rs2_data);
			br_ltu:  taken = rs1_data < rs2_data;
			br_geu:  taken = rs1_data >= rs2_data;
			default: taken = 1'b0;
		endcase
	end

	assign jmp_cond  = cmd_jal | cmd_jalr | (cmd_br & taken);
	assign link_data = pc_byte + 32'd4;

endmodule

`default_nettype wire

/* hdl/csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
	parameter logic [31:2] mtvec_reset = 30'h0000_0040
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        csr_we,
	input  wire logic [11:0] csr_adr,
	input  wire logic [2:0]  csr_op,
	input  wire logic [31:0] csr_wsrc,
	input  wire logic        trap_req,
	input  wire logic [31:0] trap_cause,
	input  wire logic        mret_req,
	input  wire logic [31:2] pc_ex,
	output logic      [31:0] csr_rdata,
	output logic      [31:2] redirect_adr,
	output logic             mie_bit
);

	import rv_ex_pkg::*;

	// only meie, mtie and msie exist in mie
	localparam logic [31:0] mie_mask = 32'h0000_0888;

	logic        mstatus_mie;
	logic        mstatus_mpie;
	logic [31:0] mie_r;
	logic [31:2] mtvec_r;
	logic [31:0] mscratch_r;
	logic [31:2] mepc_r;
	logic [31:0] mcause_r;
	logic [31:0] mstatus_val;
	logic [31:0] new_val;

	// mpp is hardwired to machine mode
	assign mstatus_val = {19'd0, 2'b11, 3'd0, mstatus_mpie, 3'd0, mstatus_mie, 3'd0};

	always_comb begin
		case (csr_adr)
			csr_mstatus:  csr_rdata = mstatus_val;
			csr_mie:      csr_rdata = mie_r;
			csr_mtvec:    csr_rdata = {mtvec_r, 2'b00};
			csr_mscratch: csr_rdata = mscratch_r;
			csr_mepc:     csr_rdata = {mepc_r, 2'b00};
			csr_mcause:   csr_rdata = mcause_r;
			default:      csr_rdata = 32'd0;
		endcase
	end

	// read-modify-write source
	always_comb begin
		case (csr_op)
			csr_rw, csr_rwi: new_val = csr_wsrc;
			csr_rs, csr_rsi: new_val = csr_rdata | csr_wsrc;
			csr_rc, csr_rci: new_val = csr_rdata & ~csr_wsrc;
			default:         new_val = csr_rdata;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_r        <= 32'd0;
			mtvec_r      <= mtvec_reset;
			mscratch_r   <= 32'd0;
			mepc_r       <= 30'd0;
			mcause_r     <= 32'd0;
		end else if (trap_req) begin
			mepc_r       <= pc_ex;
			mcause_r     <= trap_cause;
			mstatus_mpie <= mstatus_mie;
			mstatus_mie  <= 1'b0;
		end else if (mret_req) begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end else if (csr_we) begin
			case (csr_adr)
				csr_mstatus: begin
					mstatus_mie  <= new_val[3];
					mstatus_mpie <= new_val[7];
				end
				csr_mie:      mie_r      <= new_val & mie_mask;
				csr_mtvec:    mtvec_r    <= new_val[31:2];
				csr_mscratch: mscratch_r <= new_val;
				csr_mepc:     mepc_r     <= new_val[31:2];
				csr_mcause:   mcause_r   <= new_val;
				default: begin
				end
			endcase
		end
	end

	// trap goes to the vector, mret back to mepc
	assign redirect_adr = mret_req ? mepc_r : mtvec_r;
	assign mie_bit      = mstatus_mie;

	// both come from one-hot decoder strobes upstream
	a_trap_mret_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(trap_req && mret_req));

endmodule

`default_nettype wire

/* hdl/execution.sv */
`timescale 1ns/1ps
`default_nettype none

module execution (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [31:0] rs1_data,
	input  wire logic [31:0] rs2_data,
	input  wire logic        cmd_lui,
	input  wire logic        cmd_auipc,
	input  wire logic        cmd_ld,
	input  wire logic        cmd_st,
	input  wire logic        cmd_alu,
	input  wire logic        cmd_alui,
	input  wire logic        cmd_alui_shamt,
	input  wire logic        cmd_jal,
	input  wire logic        cmd_jalr,
	input  wire logic        cmd_br,
	input  wire logic        cmd_csr,
	input  wire logic        cmd_ecall,
	input  wire logic        cmd_mret,
	input  wire logic        illegal_op,
	input  wire logic        alu_sub,
	input  wire logic [2:0]  funct3,
	input  wire logic [31:12] imm_u,
	input  wire logic [11:0] imm_i,
	input  wire logic [11:0] imm_s,
	input  wire logic [4:0]  shamt,
	input  wire logic [4:0]  csr_uimm,
	input  wire logic [4:0]  rd_adr,
	input  wire logic        wbk_rd,
	input  wire logic        cpu_stat_ex,
	input  wire logic [31:0] alu_result,
	input  wire logic [31:0] target,
	input  wire logic [31:0] link_data,
	input  wire logic [31:0] csr_rdata,
	output logic      [31:0] op_a,
	output logic      [31:0] op_b,
	output logic      [2:0]  alu_func,
	output logic             alu_sub_q,
	output logic             csr_we,
	output logic      [31:0] csr_wsrc,
	output logic             trap_req,
	output logic      [31:0] trap_cause,
	output logic             mret_req,
	output logic             trap_ex,
	output logic             cmd_ld_ma,
	output logic             cmd_st_ma,
	output logic             wbk_rd_ma,
	output logic      [4:0]  rd_adr_ma,
	output logic      [31:0] rd_data_ma,
	output logic      [31:0] st_data_ma,
	output logic      [2:0]  ldst_code_ma
);

	import rv_ex_pkg::*;

	logic [31:0] imm_i_sx;
	logic [31:0] imm_s_sx;
	logic [31:0] rd_data;
	logic        trap_cmd;
	logic        issue;

	assign imm_i_sx = {{20{imm_i[11]}}, imm_i};
	assign imm_s_sx = {{20{imm_s[11]}}, imm_s};

	// operand preselect
	assign op_a = rs1_data;
	assign op_b = (cmd_ld | cmd_alui) ? imm_i_sx :
	              cmd_st              ? imm_s_sx :
	              cmd_alui_shamt      ? {27'd0, shamt} :
	                                    rs2_data;

	// address generation always adds
	assign alu_func  = (cmd_ld | cmd_st) ? alu_add : funct3;
	// addi has no sub; srai keeps its arithmetic bit
	assign alu_sub_q = alu_sub & (cmd_alu | cmd_alui_shamt);

	// csr side, uimm forms have funct3[2] set
	assign csr_we   = cmd_csr & cpu_stat_ex;
	assign csr_wsrc = funct3[2] ? {27'd0, csr_uimm} : rs1_data;

	assign trap_cmd   = cmd_ecall | illegal_op;
	assign trap_req   = trap_cmd & cpu_stat_ex;
	assign trap_cause = illegal_op ? cause_illegal : cause_ecall_m;
	assign mret_req   = cmd_mret & cpu_stat_ex;
	assign trap_ex    = trap_req;

	// write-back value priority
	assign rd_data = cmd_lui              ? {imm_u, 12'd0} :
	                 (cmd_jal | cmd_jalr) ? link_data :
	                 cmd_auipc            ? target :
	                 cmd_csr              ? csr_rdata :
	                                        alu_result;

	// a trapping instruction issues nothing downstream
	assign issue = cpu_stat_ex & ~trap_cmd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_ld_ma <= 1'b0;
			cmd_st_ma <= 1'b0;
			wbk_rd_ma <= 1'b0;
		end else begin
			cmd_ld_ma <= cmd_ld & issue;
			cmd_st_ma <= cmd_st & issue;
			wbk_rd_ma <= wbk_rd & issue;
		end
	end

	// payload follows every cycle
	always_ff @(posedge clk) begin
		rd_adr_ma    <= rd_adr;
		rd_data_ma   <= rd_data;
		st_data_ma   <= rs2_data;
		ldst_code_ma <= funct3;
	end

	a_cmd_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_stat_ex |-> $onehot0({cmd_lui, cmd_auipc, cmd_ld, cmd_st, cmd_alu,
		                          cmd_alui, cmd_alui_shamt, cmd_jal, cmd_jalr, cmd_br,
		                          cmd_csr, cmd_ecall, cmd_mret, illegal_op}));

endmodule

`default_nettype wire

/* hdl/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
	parameter logic [31:2] mtvec_reset = 30'h0000_0040
) (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic [31:0] rs1_data,
	input  wire logic [31:0] rs2_data,
	input  wire logic [31:2] pc_ex,
	input  wire logic        cmd_lui,
	input  wire logic        cmd_auipc,
	input  wire logic        cmd_ld,
	input  wire logic        cmd_st,
	input  wire logic        cmd_alu,
	input  wire logic        cmd_alui,
	input  wire logic        cmd_alui_shamt,
	input  wire logic        cmd_jal,
	input  wire logic        cmd_jalr,
	input  wire logic        cmd_br,
	input  wire logic        cmd_csr,
	input  wire logic        cmd_ecall,
	input  wire logic        cmd_mret,
	input  wire logic        illegal_op,
	input  wire logic        alu_sub,
	input  wire logic [2:0]  funct3,
	input  wire logic [31:12] imm_u,
	input  wire logic [11:0] imm_i,
	input  wire logic [11:0] imm_s,
	input  wire logic [20:1] imm_j,
	input  wire logic [12:1] imm_b,
	input  wire logic [4:0]  shamt,
	input  wire logic [11:0] csr_adr,
	input  wire logic [4:0]  csr_uimm,
	input  wire logic [4:0]  rd_adr,
	input  wire logic        wbk_rd,
	input  wire logic        cpu_stat_ex,
	output logic      [31:2] jmp_adr_ex,
	output logic             jmp_cond_ex,
	output logic             trap_ex,
	output logic      [31:2] redirect_adr,
	output logic             cmd_ld_ma,
	output logic             cmd_st_ma,
	output logic             wbk_rd_ma,
	output logic      [4:0]  rd_adr_ma,
	output logic      [31:0] rd_data_ma,
	output logic      [31:0] st_data_ma,
	output logic      [2:0]  ldst_code_ma,
	output logic             mie_bit
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [2:0]  alu_func;
	logic        alu_sub_q;
	logic [31:0] alu_result;
	logic [31:0] target;
	logic [31:0] link_data;
	logic [31:0] csr_rdata;
	logic        csr_we;
	logic [31:0] csr_wsrc;
	logic        trap_req;
	logic [31:0] trap_cause;
	logic        mret_req;

	execution execution_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.cmd_lui        (cmd_lui),
		.cmd_auipc      (cmd_auipc),
		.cmd_ld         (cmd_ld),
		.cmd_st         (cmd_st),
		.cmd_alu        (cmd_alu),
		.cmd_alui       (cmd_alui),
		.cmd_alui_shamt (cmd_alui_shamt),
		.cmd_jal        (cmd_jal),
		.cmd_jalr       (cmd_jalr),
		.cmd_br         (cmd_br),
		.cmd_csr        (cmd_csr),
		.cmd_ecall      (cmd_ecall),
		.cmd_mret       (cmd_mret),
		.illegal_op     (illegal_op),
		.alu_sub        (alu_sub),
		.funct3         (funct3),
		.imm_u          (imm_u),
		.imm_i          (imm_i),
		.imm_s          (imm_s),
		.shamt          (shamt),
		.csr_uimm       (csr_uimm),
		.rd_adr         (rd_adr),
		.wbk_rd         (wbk_rd),
		.cpu_stat_ex    (cpu_stat_ex),
		.alu_result     (alu_result),
		.target         (target),
		.link_data      (link_data),
		.csr_rdata      (csr_rdata),
		.op_a           (op_a),
		.op_b           (op_b),
		.alu_func       (alu_func),
		.alu_sub_q      (alu_sub_q),
		.csr_we         (csr_we),
		.csr_wsrc       (csr_wsrc),
		.trap_req       (trap_req),
		.trap_cause     (trap_cause),
		.mret_req       (mret_req),
		.trap_ex        (trap_ex),
		.cmd_ld_ma      (cmd_ld_ma),
		.cmd_st_ma      (cmd_st_ma),
		.wbk_rd_ma      (wbk_rd_ma),
		.rd_adr_ma      (rd_adr_ma),
		.rd_data_ma     (rd_data_ma),
		.st_data_ma     (st_data_ma),
		.ldst_code_ma   (ldst_code_ma)
	);

	ex_alu ex_alu_i (
		.op_a       (op_a),
		.op_b       (op_b),
		.alu_func   (alu_func),
		.alu_sub    (alu_sub_q),
		.alu_result (alu_result)
	);

	ex_branch ex_branch_i (
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.pc_ex     (pc_ex),
		.cmd_jal   (cmd_jal),
		.cmd_jalr  (cmd_jalr),
		.cmd_br    (cmd_br),
		.cmd_auipc (cmd_auipc),
		.funct3    (funct3),
		.imm_j     (imm_j),
		.imm_b     (imm_b),
		.imm_i     (imm_i),
		.imm_u     (imm_u),
		.jmp_adr   (jmp_adr_ex),
		.jmp_cond  (jmp_cond_ex),
		.target    (target),
		.link_data (link_data)
	);

	csr_file #(
		.mtvec_reset (mtvec_reset)
	) csr_file_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.csr_we       (csr_we),
		.csr_adr      (csr_adr),
		.csr_op       (funct3),
		.csr_wsrc     (csr_wsrc),
		.trap_req     (trap_req),
		.trap_cause   (trap_cause),
		.mret_req     (mret_req),
		.pc_ex        (pc_ex),
		.csr_rdata    (csr_rdata),
		.redirect_adr (redirect_adr),
		.mie_bit      (mie_bit)
	);

endmodule

`default_nettype wire

/* tb/tb_ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

	import rv_ex_pkg::*;

	localparam logic [31:2] mtvec_init = 30'h0000_0100;
	// reset 9, reset check 1, alu 19, control 16, load/store 4, csr 14, traps 9
	localparam int test_cycles = 72;
	localparam int cycle_limit = test_cycles + 50;

	logic        clk;
	logic        rst_n;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:2] pc_ex;
	logic        cmd_lui;
	logic        cmd_auipc;
	logic        cmd_ld;
	logic        cmd_st;
	logic        cmd_alu;
	logic        cmd_alui;
	logic        cmd_alui_shamt;
	logic        cmd_jal;
	logic        cmd_jalr;
	logic        cmd_br;
	logic        cmd_csr;
	logic        cmd_ecall;
	logic        cmd_mret;
	logic        illegal_op;
	logic        alu_sub;
	logic [2:0]  funct3;
	logic [31:12] imm_u;
	logic [11:0] imm_i;
	logic [11:0] imm_s;
	logic [20:1] imm_j;
	logic [12:1] imm_b;
	logic [4:0]  shamt;
	logic [11:0] csr_adr;
	logic [4:0]  csr_uimm;
	logic [4:0]  rd_adr;
	logic        wbk_rd;
	logic        cpu_stat_ex;
	logic [31:2] jmp_adr_ex;
	logic        jmp_cond_ex;
	logic        trap_ex;
	logic [31:2] redirect_adr;
	logic        cmd_ld_ma;
	logic        cmd_st_ma;
	logic        wbk_rd_ma;
	logic [4:0]  rd_adr_ma;
	logic [31:0] rd_data_ma;
	logic [31:0] st_data_ma;
	logic [2:0]  ldst_code_ma;
	logic        mie_bit;

	logic [15:0] lfsr;
	int          errors;
	int          checks;
	int          cycle_count;

	// expected machine csr state
	logic [31:0] m_mscratch;
	logic [31:0] m_mtvec;
	logic [31:0] m_mepc;
	logic [31:0] m_mcause;
	logic        m_mie;
	logic        m_mpie;

	ex_top #(
		.mtvec_reset (mtvec_init)
	) ex_top_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.pc_ex          (pc_ex),
		.cmd_lui        (cmd_lui),
		.cmd_auipc      (cmd_auipc),
		.cmd_ld         (cmd_ld),
		.cmd_st         (cmd_st),
		.cmd_alu        (cmd_alu),
		.cmd_alui       (cmd_alui),
		.cmd_alui_shamt (cmd_alui_shamt),
		.cmd_jal        (cmd_jal),
		.cmd_jalr       (cmd_jalr),
		.cmd_br         (cmd_br),
		.cmd_csr        (cmd_csr),
		.cmd_ecall      (cmd_ecall),
		.cmd_mret       (cmd_mret),
		.illegal_op     (illegal_op),
		.alu_sub        (alu_sub),
		.funct3         (funct3),
		.imm_u          (imm_u),
		.imm_i          (imm_i),
		.imm_s          (imm_s),
		.imm_j          (imm_j),
		.imm_b          (imm_b),
		.shamt          (shamt),
		.csr_adr        (csr_adr),
		.csr_uimm       (csr_uimm),
		.rd_adr         (rd_adr),
		.wbk_rd         (wbk_rd),
		.cpu_stat_ex    (cpu_stat_ex),
		.jmp_adr_ex     (jmp_adr_ex),
		.jmp_cond_ex    (jmp_cond_ex),
		.trap_ex        (trap_ex),
		.redirect_adr   (redirect_adr),
		.cmd_ld_ma      (cmd_ld_ma),
		.cmd_st_ma      (cmd_st_ma),
		.wbk_rd_ma      (wbk_rd_ma),
		.rd_adr_ma      (rd_adr_ma),
		.rd_data_ma     (rd_data_ma),
		.st_data_ma     (st_data_ma),
		.ldst_code_ma   (ldst_code_ma),
		.mie_bit        (mie_bit)
	);

	always #20 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] w);
		w = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] alu_model(input logic [2:0] f, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		logic [31:0] r;
		sa = a;
		case (f)
			alu_add:  r = sub ? a - b : a + b;
			alu_sll:  r = a << b[4:0];
			alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
			alu_xor:  r = a ^ b;
			alu_sr: begin
				if (sub) begin
					r = sa >>> b[4:0];
				end else begin
					r = a >> b[4:0];
				end
			end
			alu_or:   r = a | b;
			default:  r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_model(input logic [2:0] kind, input logic [31:0] a,
			input logic [31:0] b);
		case (kind)
			br_eq:   return a == b;
			br_ne:   return a != b;
			br_lt:   return $signed(a) < $signed(b);
			br_ge:   return !($signed(a) < $signed(b));
			br_ltu:  return a < b;
			br_geu:  return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] csr_model(input logic [11:0] adr);
		case (adr)
			csr_mstatus:  return 32'h0000_1800 | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
			csr_mtvec:    return m_mtvec;
			csr_mscratch: return m_mscratch;
			csr_mepc:     return m_mepc;
			csr_mcause:   return m_mcause;
			default:      return 32'd0;
		endcase
	endfunction

	task automatic csr_update(input logic [11:0] adr, input logic [31:0] v);
		case (adr)
			csr_mstatus: begin
				m_mie  = v[3];
				m_mpie = v[7];
			end
			csr_mtvec:    m_mtvec    = v & 32'hffff_fffc;
			csr_mscratch: m_mscratch = v;
			csr_mepc:     m_mepc     = v & 32'hffff_fffc;
			csr_mcause:   m_mcause   = v;
			default: begin
			end
		endcase
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected,
				actual);
		end
	endtask

	task automatic clear_cmds();
		cmd_lui        = 1'b0;
		cmd_auipc      = 1'b0;
		cmd_ld         = 1'b0;
		cmd_st         = 1'b0;
		cmd_alu        = 1'b0;
		cmd_alui       = 1'b0;
		cmd_alui_shamt = 1'b0;
		cmd_jal        = 1'b0;
		cmd_jalr       = 1'b0;
		cmd_br         = 1'b0;
		cmd_csr        = 1'b0;
		cmd_ecall      = 1'b0;
		cmd_mret       = 1'b0;
		illegal_op     = 1'b0;
		alu_sub        = 1'b0;
		funct3         = 3'd0;
		wbk_rd         = 1'b0;
		cpu_stat_ex    = 1'b0;
	endtask

	// form 0 register, 1 immediate, 2 shamt
	task automatic alu_op(input logic [1:0] form, input logic [2:0] f, input logic sub);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] wb;
		logic [31:0] dst;
		logic [31:0] eff_b;
		random_bits(32, a);
		random_bits(32, b);
		random_bits(1, wb);
		random_bits(5, dst);
		clear_cmds();
		rs1_data = a;
		rs2_data = b;
		imm_i    = b[11:0];
		// shamt kept apart from rs2[4:0]
		shamt    = ~b[4:0];
		if (form == 2'd0) begin
			cmd_alu = 1'b1;
			eff_b   = b;
		end else if (form == 2'd1) begin
			cmd_alui = 1'b1;
			eff_b    = sext12(b[11:0]);
		end else begin
			cmd_alui_shamt = 1'b1;
			eff_b          = {27'd0, ~b[4:0]};
		end
		funct3      = f;
		alu_sub     = sub;
		wbk_rd      = wb[0];
		rd_adr      = dst[4:0];
		cpu_stat_ex = 1'b1;
		@(negedge clk);
		// immediate forms never subtract
		check_value("rd_data_ma", rd_data_ma,
			alu_model(f, (form == 2'd1) ? 1'b0 : sub, a, eff_b));
		check_value("wbk_rd_ma", 32'(wbk_rd_ma), 32'(wb[0]));
		check_value("rd_adr_ma", 32'(rd_adr_ma), dst);
	endtask

	task automatic branch_op(input logic [2:0] kind, input logic same);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc;
		logic [31:0] off;
		logic [31:0] tgt;
		random_bits(32, a);
		random_bits(32, b);
		random_bits(30, pc);
		random_bits(12, off);
		if (same) begin
			b = a;
		end
		clear_cmds();
		cmd_br      = 1'b1;
		funct3      = kind;
		rs1_data    = a;
		rs2_data    = b;
		pc_ex       = pc[29:0];
		imm_b       = off[11:0];
		cpu_stat_ex = 1'b1;
		#1;
		tgt = {pc[29:0], 2'b00} + {{19{off[11]}}, off[11:0], 1'b0};
		check_value("jmp_cond_ex", 32'(jmp_cond_ex), 32'(branch_model(kind, a, b)));
		check_value("jmp_adr_ex", 32'(jmp_adr_ex), 32'(tgt[31:2]));
		@(negedge clk);
	endtask

	task automatic jump_op(input logic is_jalr);
		logic [31:0] a;
		logic [31:0] pc;
		logic [31:0] off;
		logic [31:0] tgt;
		random_bits(32, a);
		random_bits(30, pc);
		random_bits(20, off);
		clear_cmds();
		rs1_data = a;
		pc_ex    = pc[29:0];
		imm_i    = off[11:0];
		imm_j    = off[19:0];
		if (is_jalr) begin
			cmd_jalr = 1'b1;
			tgt      = a + sext12(off[11:0]);
		end else begin
			cmd_jal = 1'b1;
			tgt     = {pc[29:0], 2'b00} + {{11{off[19]}}, off[19:0], 1'b0};
		end
		wbk_rd      = 1'b1;
		cpu_stat_ex = 1'b1;
		#1;
		check_value("jmp_cond_ex", 32'(jmp_cond_ex), 32'd1);
		check_value("jmp_adr_ex", 32'(jmp_adr_ex), 32'(tgt[31:2]));
		@(negedge clk);
		check_value("rd_data_ma", rd_data_ma, {pc[29:0], 2'b00} + 32'd4);
		check_value("wbk_rd_ma", 32'(wbk_rd_ma), 32'd1);
	endtask

	task automatic upper_op(input logic is_auipc);
		logic [31:0] pc;
		logic [31:0] u;
		random_bits(30, pc);
		random_bits(20, u);
		clear_cmds();
		cmd_lui     = ~is_auipc;
		cmd_auipc   = is_auipc;
		pc_ex       = pc[29:0];
		imm_u       = u[19:0];
		wbk_rd      = 1'b1;
		cpu_stat_ex = 1'b1;
		#1;
		check_value("jmp_cond_ex", 32'(jmp_cond_ex), 32'd0);
		@(negedge clk);
		if (is_auipc) begin
			check_value("rd_data_ma", rd_data_ma, {pc[29:0], 2'b00} + {u[19:0], 12'd0});
		end else begin
			check_value("rd_data_ma", rd_data_ma, {u[19:0], 12'd0});
		end
	endtask

	task automatic ldst_op(input logic is_st, input logic live);
		logic [31:0] base;
		logic [31:0] off;
		logic [31:0] data;
		logic [31:0] width;
		random_bits(32, base);
		random_bits(12, off);
		random_bits(32, data);
		random_bits(3, width);
		clear_cmds();
		cmd_ld      = ~is_st;
		cmd_st      = is_st;
		rs1_data    = base;
		rs2_data    = data;
		// the unused immediate gets the inverted bits
		imm_i       = is_st ? ~off[11:0] : off[11:0];
		imm_s       = is_st ? off[11:0] : ~off[11:0];
		funct3      = width[2:0];
		wbk_rd      = ~is_st;
		cpu_stat_ex = live;
		@(negedge clk);
		check_value("cmd_ld_ma", 32'(cmd_ld_ma), 32'(live & ~is_st));
		check_value("cmd_st_ma", 32'(cmd_st_ma), 32'(live & is_st));
		check_value("wbk_rd_ma", 32'(wbk_rd_ma), 32'(live & ~is_st));
		check_value("rd_data_ma", rd_data_ma, base + sext12(off[11:0]));
		check_value("st_data_ma", st_data_ma, data);
		check_value("ldst_code_ma", 32'(ldst_code_ma), width);
	endtask

	task automatic csr_access(input logic [2:0] op, input logic [11:0] adr,
			input logic [31:0] src, input logic [4:0] uimm);
		logic [31:0] old_val;
		logic [31:0] wsrc;
		logic [31:0] new_val;
		old_val = csr_model(adr);
		wsrc    = op[2] ? 32'(uimm) : src;
		case (op)
			csr_rw, csr_rwi: new_val = wsrc;
			csr_rs, csr_rsi: new_val = old_val | wsrc;
			default:         new_val = old_val & ~wsrc;
		endcase
		clear_cmds();
		cmd_csr     = 1'b1;
		funct3      = op;
		csr_adr     = adr;
		rs1_data    = src;
		csr_uimm    = uimm;
		wbk_rd      = 1'b1;
		rd_adr      = 5'd7;
		cpu_stat_ex = 1'b1;
		@(negedge clk);
		check_value("rd_data_ma", rd_data_ma, old_val);
		check_value("wbk_rd_ma", 32'(wbk_rd_ma), 32'd1);
		csr_update(adr, new_val);
	endtask

	task automatic csr_read(input logic [11:0] adr);
		csr_access(csr_rs, adr, 32'd0, 5'd0);
	endtask

	task automatic csr_series(input logic [11:0] adr);
		logic [31:0] v;
		random_bits(32, v);
		csr_access(csr_rw, adr, v, 5'd0);
		random_bits(32, v);
		csr_access(csr_rs, adr, v, 5'd0);
		random_bits(32, v);
		csr_access(csr_rc, adr, v, 5'd0);
		random_bits(5, v);
		csr_access(csr_rwi, adr, 32'd0, v[4:0]);
		random_bits(5, v);
		csr_access(csr_rsi, adr, 32'd0, v[4:0]);
		random_bits(5, v);
		csr_access(csr_rci, adr, 32'd0, v[4:0]);
		csr_read(adr);
	endtask

	task automatic trap_op(input logic is_illegal);
		logic [31:0] pc;
		random_bits(30, pc);
		clear_cmds();
		cmd_ecall   = ~is_illegal;
		illegal_op  = is_illegal;
		pc_ex       = pc[29:0];
		wbk_rd      = 1'b1;
		cpu_stat_ex = 1'b1;
		#1;
		check_value("trap_ex", 32'(trap_ex), 32'd1);
		check_value("redirect_adr", 32'(redirect_adr), 32'(m_mtvec[31:2]));
		@(negedge clk);
		m_mepc   = {pc[29:0], 2'b00};
		m_mcause = is_illegal ? cause_illegal : cause_ecall_m;
		m_mpie   = m_mie;
		m_mie    = 1'b0;
		check_value("wbk_rd_ma", 32'(wbk_rd_ma), 32'd0);
		check_value("mie_bit", 32'(mie_bit), 32'd0);
		csr_read(csr_mepc);
		csr_read(csr_mcause);
	endtask

	task automatic mret_op();
		clear_cmds();
		cmd_mret    = 1'b1;
		cpu_stat_ex = 1'b1;
		#1;
		check_value("trap_ex", 32'(trap_ex), 32'd0);
		check_value("redirect_adr", 32'(redirect_adr), 32'(m_mepc[31:2]));
		@(negedge clk);
		m_mie  = m_mpie;
		m_mpie = 1'b1;
		check_value("mie_bit", 32'(mie_bit), 32'(m_mie));
	endtask

	task automatic test_reset();
		check_value("cmd_ld_ma", 32'(cmd_ld_ma), 32'd0);
		check_value("cmd_st_ma", 32'(cmd_st_ma), 32'd0);
		check_value("wbk_rd_ma", 32'(wbk_rd_ma), 32'd0);
		check_value("mie_bit", 32'(mie_bit), 32'd0);
		csr_read(csr_mtvec);
	endtask

	task automatic test_alu();
		for (int f = 0; f < 8; f++) begin
			alu_op(2'd0, 3'(f), 1'b0);
		end
		alu_op(2'd0, alu_add, 1'b1);
		alu_op(2'd0, alu_sr, 1'b1);
		// alu_sub set on addi must not turn it into a subtract
		alu_op(2'd1, alu_add, 1'b1);
		alu_op(2'd1, alu_slt, 1'b0);
		alu_op(2'd1, alu_sltu, 1'b0);
		alu_op(2'd1, alu_xor, 1'b0);
		alu_op(2'd1, alu_or, 1'b0);
		alu_op(2'd1, alu_and, 1'b0);
		alu_op(2'd2, alu_sll, 1'b0);
		alu_op(2'd2, alu_sr, 1'b0);
		alu_op(2'd2, alu_sr, 1'b1);
	endtask

	task automatic test_control();
		// funct3 2 and 3 are not branch kinds
		for (int k = 0; k < 8; k++) begin
			if (k != 2 && k != 3) begin
				branch_op(3'(k), 1'b0);
				branch_op(3'(k), 1'b1);
			end
		end
		jump_op(1'b0);
		jump_op(1'b1);
		upper_op(1'b0);
		upper_op(1'b1);
	endtask

	task automatic test_ldst();
		ldst_op(1'b0, 1'b1);
		ldst_op(1'b1, 1'b1);
		ldst_op(1'b0, 1'b0);
		ldst_op(1'b1, 1'b0);
	endtask

	task automatic test_csr();
		csr_series(csr_mscratch);
		csr_series(csr_mtvec);
	endtask

	task automatic test_traps();
		// mie set first so mret has something to restore
		csr_access(csr_rsi, csr_mstatus, 32'd0, 5'd8);
		check_value("mie_bit", 32'(mie_bit), 32'd1);
		trap_op(1'b0);
		mret_op();
		trap_op(1'b1);
		mret_op();
	endtask

	initial begin
		errors     = 0;
		checks     = 0;
		lfsr       = 16'd57008;
		clk        = 1'b0;
		rst_n      = 1'b0;
		rs1_data   = 32'd0;
		rs2_data   = 32'd0;
		pc_ex      = 30'd0;
		imm_u      = 20'd0;
		imm_i      = 12'd0;
		imm_s      = 12'd0;
		imm_j      = 20'd0;
		imm_b      = 12'd0;
		shamt      = 5'd0;
		csr_adr    = 12'd0;
		csr_uimm   = 5'd0;
		rd_adr     = 5'd0;
		clear_cmds();
		m_mscratch = 32'd0;
		m_mtvec    = {mtvec_init, 2'b00};
		m_mepc     = 32'd0;
		m_mcause   = 32'd0;
		m_mie      = 1'b0;
		m_mpie     = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_alu();
		test_control();
		test_ldst();
		test_csr();
		test_traps();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run was still going after %0d clock cycles", cycle_limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/rv_ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/csr_file.sv
hdl/execution.sv
hdl/ex_top.sv
tb/tb_ex_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_ex_top
FILELIST = project.f
SIM      = obj_dir/V$(TOP)
PASS     = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
